// ==== src/convPkg.sv ====
package convPkg;

    // fixed point format q4.16, two's complement
    localparam int dataW = 20;
    localparam int fracW = 16;

    localparam int numTaps = 9;      // 3x3 window
    localparam int boothSteps = 10;  // 9 digit cycles + 1 rounding cycle

    typedef logic [dataW-1:0]   fixedT;    // one q4.16 value
    typedef logic [2*dataW-1:0] productT;  // full q8.32 product
    typedef logic [3:0]         tapIdxT;   // 0..8, row = tap/3, col = tap%3

    // kernel elements, row major from the top left tap
    localparam fixedT kernelTable [2][numTaps] = '{
        '{20'h0A89E, 20'h092D5, 20'h06D43,
          20'h01004, 20'hF8F71, 20'hF6E54,
          20'hFA6D7, 20'hFC834, 20'hFAC19},
        '{20'hFDB55, 20'h02992, 20'hFC994,
          20'h050FD, 20'h02F20, 20'h0202D,
          20'h03BD7, 20'hFD369, 20'h05E68}
    };

    // bias per channel, channel 1 is negative
    localparam fixedT biasTable [2] = '{20'h01310, 20'hF7295};

    // pixel as seen by the channels
    typedef struct packed {
        fixedT  pixel;  // already zero on padded taps
        tapIdxT tap;    // selects the kernel element
    } tapDataT;

    // one-cycle strobes from the sequencer, shared by both channels
    typedef struct packed {
        logic clearSum;    // zero the accumulator before tap 0
        logic multStart;   // launch the booth multiplier
        logic accumulate;  // add the rounded product
        logic finish;      // last tap, register biased relu result
    } channelCtrlT;

    // per tap phases of the sequencer
    typedef enum logic [2:0] {
        idle,
        fetch,       // read address stable, pixel registered on exit
        capture,     // captured pixel presented to the multipliers
        multiply,    // wait for multDone
        accumulate,
        finish,      // done high
        advance,     // step to next output pixel
        frameEnd     // wait for en to drop
    } seqStateT;

endpackage

// ==== src/boothMultiplier.sv ====
`timescale 1ns/1ps

module boothMultiplier
    import convPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,     // one cycle, operands valid with it
    input  fixedT a,         // multiplicand
    input  fixedT b,         // multiplier, recoded in radix 4
    output fixedT y,         // rounded q4.16 product
    output logic  busy,
    output logic  doneMult   // last busy cycle, y valid from the next cycle
);

    typedef logic [$clog2(boothSteps+1)-1:0] stepT;

    productT        mcandExt;   // a sign extended to product width
    productT        mcandSh;    // multiplicand at weight of the current digit
    logic [dataW:0] mplierSh;   // multiplier with the implied zero below bit 0
    productT        sum;        // partial sum of retired digits
    productT        ppLoad;
    productT        ppStep;
    stepT           stepCount;  // 1..9 digit cycles, boothSteps = rounding

    // radix-4 booth digit times multiplicand
    function automatic productT boothPp(input productT m, input logic [2:0] triplet);
        productT pp;
        case (triplet)
            3'b001, 3'b010: pp = m;         // +1
            3'b011:         pp = m << 1;    // +2
            3'b100:         pp = -(m << 1); // -2
            3'b101, 3'b110: pp = -m;        // -1
            default:        pp = '0;        // 000 and 111 add nothing
        endcase
        return pp;
    endfunction

    assign mcandExt = {{dataW{a[dataW-1]}}, a};
    assign ppLoad = boothPp(mcandExt, {b[1:0], 1'b0});  // digit 0 straight from the inputs
    assign ppStep = boothPp(mcandSh, mplierSh[2:0]);
    assign doneMult = busy && (stepCount == stepT'(boothSteps));

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy <= 1'b0;
            stepCount <= '0;
        end else if (start) begin
            busy <= 1'b1;
            stepCount <= stepT'(1);
        end else if (busy) begin
            if (doneMult) begin
                busy <= 1'b0;
                stepCount <= '0;
            end else begin
                stepCount <= stepCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sum <= ppLoad;
            mcandSh <= mcandExt << 2;
            mplierSh <= {b, 1'b0} >> 2;     // next triplet is b[3:1]
        end else if (busy && !doneMult) begin
            sum <= sum + ppStep;            // wraps in 40 bits, true product always fits
            mcandSh <= mcandSh << 2;
            mplierSh <= mplierSh >> 2;
        end
        // round to nearest on bit 15, keep q4.16 with wrap
        if (doneMult)
            y <= sum[fracW +: dataW] + fixedT'(sum[fracW-1]);
    end

    // operands and partial sum would be overwritten mid product
    startWhileBusy: assert property (@(posedge clk) disable iff (!reset) start |-> !busy)
        else $error("booth multiplier started while busy");

endmodule

// ==== src/convChannel.sv ====
`timescale 1ns/1ps

module convChannel
    import convPkg::*;
#(
    parameter int channelIdx = 0    // picks kernel row and bias
) (
    input  logic        clk,
    input  logic        reset,
    input  tapDataT     tapData,
    input  channelCtrlT ctrl,
    output logic        multDone,
    output fixedT       result      // relu(sum + bias), held until next finish
);

    fixedT kernel;     // kernel element for the current tap
    fixedT product;    // rounded pixel * kernel
    fixedT sum;        // running window sum, wraps in 20 bits
    fixedT sumNext;
    fixedT biased;
    logic  multBusy;

    assign kernel = kernelTable[channelIdx][tapData.tap];

    boothMultiplier mult0 (
        .clk      (clk),
        .reset    (reset),
        .start    (ctrl.multStart),
        .a        (tapData.pixel),
        .b        (kernel),
        .y        (product),
        .busy     (multBusy),
        .doneMult (multDone)
    );

    assign sumNext = sum + product;
    // finish comes with the last accumulate, so bias goes on the final sum
    assign biased = sumNext + biasTable[channelIdx];

    always_ff @(posedge clk) begin
        if (ctrl.clearSum)
            sum <= '0;
        else if (ctrl.accumulate)
            sum <= sumNext;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            result <= '0;
        end else if (ctrl.finish) begin
            result <= biased[dataW-1] ? '0 : biased;  // relu clips negatives
        end
    end

    // product must be settled before it is summed
    accumAfterMult: assert property (@(posedge clk) disable iff (!reset)
        ctrl.accumulate |-> !multBusy)
        else $error("channel %0d accumulated during a multiply", channelIdx);

    // result only ever taken at the end of a tap
    finishOnAccum: assert property (@(posedge clk) disable iff (!reset)
        ctrl.finish |-> ctrl.accumulate)
        else $error("channel %0d finish without accumulate", channelIdx);

endmodule

// ==== src/windowScanner.sv ====
`timescale 1ns/1ps

module windowScanner
    import convPkg::*;
#(
    parameter int imgSideLog2 = 6   // image side is 2**imgSideLog2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     nextTap,    // step to the next tap in the window
    input  logic                     nextPixel,  // step to next output in block order
    input  logic                     restart,    // back to output (0,0) tap 0
    output logic [2*imgSideLog2-1:0] addrRd,     // {row, col} of the current tap
    output logic [2*imgSideLog2-1:0] addrWr,     // {row, col} of the current output
    output logic                     padTap,     // tap lies outside the image
    output logic                     lastTap,
    output logic                     lastPixel
);

    typedef logic [imgSideLog2-1:0] coordT;
    typedef logic [imgSideLog2:0]   coordExtT;  // extra msb flags -1 and side

    coordT    rowPos;   // output position
    coordT    colPos;
    tapIdxT   tap;
    logic [1:0] tapRow; // 0..2 within the window
    logic [1:0] tapCol;
    coordExtT rowRd;    // tap coordinate, may be out of range
    coordExtT colRd;
    logic     lastCol;

    // split tap index into window row and column
    always_comb begin
        if (tap >= 4'd6)
            tapRow = 2'd2;
        else if (tap >= 4'd3)
            tapRow = 2'd1;
        else
            tapRow = 2'd0;
        tapCol = 2'(tap - 4'(3 * tapRow));
    end

    // window is centred on the output, so offset is tap row/col minus one
    assign rowRd = {1'b0, rowPos} + coordExtT'(tapRow) - coordExtT'(1);
    assign colRd = {1'b0, colPos} + coordExtT'(tapCol) - coordExtT'(1);

    assign padTap = rowRd[imgSideLog2] | colRd[imgSideLog2];  // -1 or side
    assign addrRd = {rowRd[imgSideLog2-1:0], colRd[imgSideLog2-1:0]};
    assign addrWr = {rowPos, colPos};

    assign lastTap = (tap == tapIdxT'(numTaps - 1));
    assign lastCol = &colPos;
    assign lastPixel = (&rowPos) & lastCol;  // block order ends bottom right

    always_ff @(posedge clk) begin
        if (!reset || restart) begin
            rowPos <= '0;
            colPos <= '0;
            tap <= '0;
        end else if (nextTap) begin
            tap <= tap + 1'b1;
        end else if (nextPixel) begin
            tap <= '0;
            if (!colPos[0]) begin
                colPos <= colPos + 1'b1;        // (y,x) to (y,x+1)
            end else if (!rowPos[0]) begin
                rowPos <= rowPos + 1'b1;        // (y,x+1) to (y+1,x)
                colPos <= colPos - 1'b1;
            end else begin
                // bottom right of a block, col wraps to 0 at the row end
                colPos <= colPos + 1'b1;
                rowPos <= lastCol ? rowPos + 1'b1 : rowPos - 1'b1;
            end
        end
    end

    // a step is either within the window or to the next output, never both
    stepExclusive: assert property (@(posedge clk) disable iff (!reset)
        !(nextTap && nextPixel))
        else $error("scanner got nextTap and nextPixel together");

endmodule

// ==== src/convSequencer.sv ====
`timescale 1ns/1ps

module convSequencer
    import convPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        en,         // level, low aborts to idle
    input  fixedT       data,       // image memory read data
    input  logic        padTap,
    input  logic        lastTap,
    input  logic        lastPixel,
    input  logic        multDone,
    output logic        nextTap,
    output logic        nextPixel,
    output logic        restart,
    output tapDataT     tapData,
    output channelCtrlT ctrl,
    output logic        done,       // one cycle per output pixel
    output logic        frameDone   // one cycle after the last pixel
);

    seqStateT state;
    seqStateT stateNext;
    tapIdxT   tapCount;  // kernel index, tracks the scanner tap

    always_comb begin
        stateNext = state;
        case (state)
            idle:       if (en) stateNext = fetch;
            fetch:      stateNext = capture;
            capture:    stateNext = multiply;
            multiply:   if (multDone) stateNext = accumulate;
            accumulate: stateNext = lastTap ? finish : fetch;
            finish:     stateNext = advance;
            advance:    stateNext = lastPixel ? frameEnd : fetch;
            frameEnd:   stateNext = frameEnd;  // hold until en drops
            default:    stateNext = idle;
        endcase
        if (!en)
            stateNext = idle;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= idle;
            tapCount <= '0;
            frameDone <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == idle || state == advance)
                tapCount <= '0;
            else if (state == accumulate)
                tapCount <= tapCount + 1'b1;
            frameDone <= (state == advance) && lastPixel && en;
        end
    end

    // memory answers within the fetch cycle, pixel lands on the edge into capture
    always_ff @(posedge clk) begin
        if (state == fetch) begin
            tapData.pixel <= padTap ? '0 : data;
            tapData.tap <= tapCount;
        end
    end

    // channel strobes
    always_comb begin
        ctrl.clearSum = (state == advance) || (state == idle && en);
        ctrl.multStart = (state == capture);
        ctrl.accumulate = (state == accumulate);
        ctrl.finish = (state == accumulate) && lastTap;  // result registered with the last sum
    end

    assign nextTap = (state == accumulate) && !lastTap;
    assign nextPixel = (state == advance);
    assign restart = (state == idle);   // scanner parked at (0,0) while idle
    assign done = (state == finish);

    // downstream pooling counts one pulse per pixel
    singleDone: assert property (@(posedge clk) disable iff (!reset) done |=> !done)
        else $error("done held high for two cycles");

endmodule

// ==== src/convLayer.sv ====
`timescale 1ns/1ps

module convLayer
    import convPkg::*;
#(
    parameter int imgSideLog2 = 6
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     en,
    input  fixedT                    data,
    output logic [2*imgSideLog2-1:0] addrRd,
    output logic [2*imgSideLog2-1:0] addrWr,
    output fixedT                    resultK0,
    output fixedT                    resultK1,
    output logic                     done,
    output logic                     frameDone
);

    logic        padTap;
    logic        lastTap;
    logic        lastPixel;
    logic        nextTap;
    logic        nextPixel;
    logic        restart;
    logic        multDone;  // channels run in lockstep, channel 0 speaks for both
    tapDataT     tapData;
    channelCtrlT ctrl;

    windowScanner #(.imgSideLog2(imgSideLog2)) scan0 (
        .clk       (clk),
        .reset     (reset),
        .nextTap   (nextTap),
        .nextPixel (nextPixel),
        .restart   (restart),
        .addrRd    (addrRd),
        .addrWr    (addrWr),
        .padTap    (padTap),
        .lastTap   (lastTap),
        .lastPixel (lastPixel)
    );

    convSequencer seq0 (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .data      (data),
        .padTap    (padTap),
        .lastTap   (lastTap),
        .lastPixel (lastPixel),
        .multDone  (multDone),
        .nextTap   (nextTap),
        .nextPixel (nextPixel),
        .restart   (restart),
        .tapData   (tapData),
        .ctrl      (ctrl),
        .done      (done),
        .frameDone (frameDone)
    );

    convChannel #(.channelIdx(0)) chan0 (
        .clk      (clk),
        .reset    (reset),
        .tapData  (tapData),
        .ctrl     (ctrl),
        .multDone (multDone),
        .result   (resultK0)
    );

    convChannel #(.channelIdx(1)) chan1 (
        .clk      (clk),
        .reset    (reset),
        .tapData  (tapData),
        .ctrl     (ctrl),
        .multDone (),
        .result   (resultK1)
    );

endmodule

// ==== sim/convChecker.sv ====
`timescale 1ns/1ps

module convChecker
    import convPkg::*;
#(
    parameter int imgSideLog2 = 6
) (
    input logic                                  clk,
    input logic                                  reset,
    input logic                                  en,
    input logic                                  done,
    input logic                                  frameDone,
    input logic [2*imgSideLog2-1:0]              addrWr,
    input fixedT                                 resultK0,
    input fixedT                                 resultK1,
    input fixedT [(1<<(2*imgSideLog2))-1:0]      image      // same image the memory model serves
);

    localparam int side = 1 << imgSideLog2;
    localparam int numPix = side * side;

    string       testName = "none";
    int          expPulses = numPix;
    int          errorCount = 0;
    int          mismatches = 0;   // [FAIL] lines
    int          otherErrors = 0;  // protocol and timeout problems
    int          pixelsChecked = 0;
    int          outIdx = 0;       // position in block order within the frame
    logic        enQ = 1'b0;       // en as seen at the last rising edge
    logic [31:0] dutSum = '0;
    logic [31:0] modelSum = '0;

    // k-th output of the 2x2 block scan, as row*side + col
    function automatic int blockAddr(input int k);
        int blk;
        int y;
        int x;
        blk = k / 4;
        y = 2 * (blk / (side / 2)) + (k % 4) / 2;
        x = 2 * (blk % (side / 2)) + k % 2;
        return y * side + x;
    endfunction

    // q4.16 window sum with zero padding, rounding on bit 15, 20-bit wrap, bias, relu
    function automatic fixedT modelPixel(input int c, input int y, input int x);
        fixedT  sum;
        fixedT  rounded;
        fixedT  biased;
        longint prod;
        int     t;
        int     r;
        int     q;
        sum = '0;
        for (t = 0; t < numTaps; t++) begin
            r = y + t / 3 - 1;
            q = x + t % 3 - 1;
            if (r >= 0 && r < side && q >= 0 && q < side) begin  // padded taps add nothing
                prod = longint'($signed(image[r*side+q])) * longint'($signed(kernelTable[c][t]));
                rounded = fixedT'(prod >>> fracW) + fixedT'((prod >>> (fracW - 1)) & 1);
                sum = sum + rounded;
            end
        end
        biased = sum + biasTable[c];
        return biased[dataW-1] ? '0 : biased;
    endfunction

    function automatic logic [31:0] foldSum(input logic [31:0] acc, input fixedT r0,
                                            input fixedT r1);
        return {acc[30:0], acc[31]} ^ {12'h0, r0} ^ {r1, 12'h0};
    endfunction

    task automatic beginTest(input string name, input int pulses);
        testName = name;
        expPulses = pulses;
    endtask

    task automatic reportFailure(input string msg);
        otherErrors++;
        errorCount++;
        $display("ERROR in test %s: %s", testName, msg);
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            mismatches++;
            errorCount++;
            $display("[FAIL] %s %s at output %0d expected %h actual %h",
                     testName, what, outIdx, expected, actual);
        end
    endtask

    task automatic checkPixel();
        int    a;
        fixedT exp0;
        fixedT exp1;
        if (outIdx >= numPix) begin
            reportFailure("done pulsed after the last pixel of the frame");
        end else begin
            a = blockAddr(outIdx);
            exp0 = modelPixel(0, a / side, a % side);
            exp1 = modelPixel(1, a / side, a % side);
            checkValue("addrWr", a, addrWr);
            checkValue("resultK0", exp0, resultK0);
            checkValue("resultK1", exp1, resultK1);
            dutSum = foldSum(dutSum, resultK0, resultK1);
            modelSum = foldSum(modelSum, exp0, exp1);
            outIdx++;
            pixelsChecked++;
        end
    endtask

    task automatic checkFrame();
        checkValue("done count", expPulses, outIdx);
        checkValue("checksum", modelSum, dutSum);
    endtask

    task automatic printSummary();
        $display("checker: %0d errors (%0d mismatches, %0d other) over %0d pixels",
                 errorCount, mismatches, otherErrors, pixelsChecked);
    endtask

    always @(posedge clk)
        enQ <= en;

    // outputs settle after the rising edge, so compare in the middle of the cycle
    always @(negedge clk) begin
        if (!reset) begin
            outIdx = 0;
            dutSum = '0;
            modelSum = '0;
        end else if (!enQ) begin
            if (done || frameDone)
                reportFailure("done or frameDone pulsed while en was low");
            outIdx = 0;       // scan restarts at (0,0)
            dutSum = '0;
            modelSum = '0;
        end else begin
            if (done)
                checkPixel();
            if (frameDone)
                checkFrame();
        end
    end

endmodule

// ==== sim/convLayerTb.sv ====
`timescale 1ns/1ps

module convLayerTb
    import convPkg::*;
();

    localparam int imgSideLog2 = 3;                 // 8x8 images
    localparam int side = 1 << imgSideLog2;
    localparam int numPix = side * side;
    localparam int numTests = 6;
    localparam int waitLimit = 2 * numPix * 119 + 200;  // cycles, about two frames
    localparam int impulseAt = side + 2;            // (1,2), reaches the top border windows

    // image pattern codes
    localparam int patZero = 0;
    localparam int patOne = 1;
    localparam int patImpulse = 2;
    localparam int patRamp = 3;
    localparam int patRandom = 4;

    // name, pattern, done pulses before en drops (0 = straight run), expected pulses per frame
    string testName [numTests] = '{"allZero", "allOne", "impulse", "negRamp", "random",
                                   "restart"};
    int patternCode [numTests] = '{patZero, patOne, patImpulse, patRamp, patRandom, patRandom};
    int abortAfter  [numTests] = '{0, 0, 0, 0, 0, 6};
    int expPulses   [numTests] = '{numPix, numPix, numPix, numPix, numPix, numPix};

    logic                     clk = 1'b0;
    logic                     reset = 1'b0;
    logic                     en = 1'b0;
    fixedT                    data = '0;
    logic [2*imgSideLog2-1:0] addrRd;
    logic [2*imgSideLog2-1:0] addrWr;
    fixedT                    resultK0;
    fixedT                    resultK1;
    logic                     done;
    logic                     frameDone;
    fixedT [numPix-1:0]       imageMem = '0;
    integer                   seed = 32'h4643_3d93;
    logic                     timedOut = 1'b0;

    always #20 clk = ~clk;

    // image memory answers the read address half a cycle later
    always @(negedge clk)
        data = imageMem[addrRd];

    convLayer #(.imgSideLog2(imgSideLog2)) dut0 (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .data      (data),
        .addrRd    (addrRd),
        .addrWr    (addrWr),
        .resultK0  (resultK0),
        .resultK1  (resultK1),
        .done      (done),
        .frameDone (frameDone)
    );

    convChecker #(.imgSideLog2(imgSideLog2)) chk0 (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .done      (done),
        .frameDone (frameDone),
        .addrWr    (addrWr),
        .resultK0  (resultK0),
        .resultK1  (resultK1),
        .image     (imageMem)
    );

    task automatic fillImage(input int code);
        int i;
        for (i = 0; i < numPix; i++) begin
            case (code)
                patZero:    imageMem[i] = '0;
                patOne:     imageMem[i] = 20'h10000;  // 1.0
                patImpulse: imageMem[i] = (i == impulseAt) ? 20'h10000 : '0;
                patRamp:    imageMem[i] = fixedT'(-(i + 1) * 4096);  // down to -4.0
                default:    imageMem[i] = fixedT'($random(seed));
            endcase
        end
    endtask

    task automatic waitDonePulses(input int count, output logic ok);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < count && cycles < waitLimit) begin
            @(negedge clk);
            if (done)
                seen++;
            cycles++;
        end
        ok = (seen >= count);
    endtask

    task automatic waitFrameDone(output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < waitLimit) begin
            @(negedge clk);
            ok = frameDone;
            cycles++;
        end
    endtask

    initial begin
        logic ok;
        int   t;
        repeat (3) @(negedge clk);
        reset = 1'b1;
        repeat (10) @(negedge clk);  // idle with en low, checker watches for stray pulses
        for (t = 0; t < numTests && !timedOut; t++) begin
            fillImage(patternCode[t]);
            chk0.beginTest(testName[t], expPulses[t]);
            en = 1'b1;
            ok = 1'b1;
            if (abortAfter[t] > 0) begin
                waitDonePulses(abortAfter[t], ok);
                if (ok) begin
                    repeat (40) @(negedge clk);  // drop en in the middle of a window
                    en = 1'b0;
                    repeat (3) @(negedge clk);
                    en = 1'b1;
                end
            end
            if (ok)
                waitFrameDone(ok);
            if (!ok) begin
                chk0.reportFailure("timed out waiting for done or frameDone");
                timedOut = 1'b1;
            end
            en = 1'b0;
            repeat (3) @(negedge clk);
        end
        chk0.printSummary();
        if (chk0.errorCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
src/convPkg.sv
src/boothMultiplier.sv
src/convChannel.sv
src/windowScanner.sv
src/convSequencer.sv
src/convLayer.sv
sim/convChecker.sv
sim/convLayerTb.sv
